// ==== hw/rob_settings.svh ====
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// queue geometry
`define ROB_DEPTH 8
`define ROB_IDX_W 3

// datapath widths
`define XLEN 32
`define REG_IDX_W 5
`define OPC_W 7

// rv32i major opcodes with special handling at fetch or commit
`define OPC_STORE 7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_JAL 7'b1101111
`define OPC_JALR 7'b1100111

// sequential pc step
`define INSTR_STEP 4

`endif

// ==== hw/rob_pkg.sv ====
`include "rob_settings.svh"

package rob_pkg;

  // data and address values
  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`XLEN-1:0] addr_t;

  // queue slot and architectural register indices
  typedef logic [`ROB_IDX_W-1:0] rob_idx_t;
  typedef logic [`REG_IDX_W-1:0] reg_idx_t;

  // predecoded instruction fields
  typedef logic [`OPC_W-1:0] opcode_t;
  typedef logic [2:0] funct3_t;

  // 0 byte, 1 halfword, 3 word
  typedef logic [1:0] store_len_t;

  typedef enum logic {
    FETCH_IDLE,
    FETCH_WAIT
  } fetch_state_e;

  typedef enum logic {
    COMMIT_IDLE,
    COMMIT_STORING
  } commit_state_e;

endpackage

// ==== hw/fetch_sequencer.sv ====
`timescale 1ns/1ps
`include "rob_settings.svh"

module fetch_sequencer (
  input  logic              clk,
  input  logic              rst,
  output logic              fetch_req_valid,
  output rob_pkg::addr_t    fetch_req_pc,
  input  logic              fetch_req_ready,
  input  logic              fetch_rsp_valid,
  input  rob_pkg::opcode_t  rsp_opcode,
  input  rob_pkg::reg_idx_t rsp_rd,
  input  rob_pkg::funct3_t  rsp_funct3,
  input  rob_pkg::word_t    rsp_imm,
  output logic              push_valid,
  input  logic              push_ready,
  output rob_pkg::addr_t    push_pc,
  output rob_pkg::opcode_t  push_opcode,
  output rob_pkg::reg_idx_t push_rd,
  output rob_pkg::funct3_t  push_funct3,
  output rob_pkg::word_t    push_imm,
  input  logic              flush_valid,
  input  rob_pkg::addr_t    flush_pc
);

  rob_pkg::fetch_state_e state;
  rob_pkg::addr_t        pc;
  rob_pkg::addr_t        next_pc;
  logic                  discard;

  // pc stays on the requested address until its response lands
  assign fetch_req_pc = pc;

  // response goes straight into the queue in the cycle it arrives
  assign push_valid  = (state == rob_pkg::FETCH_WAIT) && fetch_rsp_valid;
  assign push_pc     = pc;
  assign push_opcode = rsp_opcode;
  assign push_rd     = rsp_rd;
  assign push_funct3 = rsp_funct3;
  assign push_imm    = rsp_imm;

  // fixed prediction: branches and jal taken, jalr falls through
  always_comb begin
    if (rsp_opcode == `OPC_BRANCH || rsp_opcode == `OPC_JAL) begin
      next_pc = pc + rsp_imm;
    end else begin
      next_pc = pc + `INSTR_STEP;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state           <= rob_pkg::FETCH_IDLE;
      pc              <= '0;
      fetch_req_valid <= 1'b0;
      discard         <= 1'b0;
    end else if (flush_valid) begin
      state           <= rob_pkg::FETCH_IDLE;
      pc              <= flush_pc;
      fetch_req_valid <= 1'b0;
      // a request already accepted still owes a response, drop it later
      discard <= (fetch_req_valid && fetch_req_ready) ||
                 ((state == rob_pkg::FETCH_WAIT || discard) && !fetch_rsp_valid);
    end else begin
      case (state)
        rob_pkg::FETCH_IDLE: begin
          if (fetch_rsp_valid) begin
            discard <= 1'b0;
          end
          if (fetch_req_valid) begin
            if (fetch_req_ready) begin
              fetch_req_valid <= 1'b0;
              state           <= rob_pkg::FETCH_WAIT;
            end
          end else if (push_ready && !discard) begin
            // only one request in flight, and never into a full queue
            fetch_req_valid <= 1'b1;
          end
        end
        rob_pkg::FETCH_WAIT: begin
          if (fetch_rsp_valid) begin
            pc    <= next_pc;
            state <= rob_pkg::FETCH_IDLE;
          end
        end
        default: begin
          state <= rob_pkg::FETCH_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== hw/reorder_queue.sv ====
`timescale 1ns/1ps
`include "rob_settings.svh"

module reorder_queue (
  input  logic              clk,
  input  logic              rst,
  input  logic              push_valid,
  output logic              push_ready,
  input  rob_pkg::addr_t    push_pc,
  input  rob_pkg::opcode_t  push_opcode,
  input  rob_pkg::reg_idx_t push_rd,
  input  rob_pkg::funct3_t  push_funct3,
  input  rob_pkg::word_t    push_imm,
  output logic              issue_valid,
  input  logic              issue_ready,
  output rob_pkg::rob_idx_t issue_idx,
  output rob_pkg::addr_t    issue_pc,
  output rob_pkg::opcode_t  issue_opcode,
  output rob_pkg::word_t    issue_imm,
  input  logic              wb_valid,
  input  rob_pkg::rob_idx_t wb_idx,
  input  rob_pkg::word_t    wb_result,
  input  rob_pkg::addr_t    wb_target,
  output logic              head_valid,
  output rob_pkg::addr_t    head_pc,
  output rob_pkg::opcode_t  head_opcode,
  output rob_pkg::reg_idx_t head_rd,
  output rob_pkg::funct3_t  head_funct3,
  output rob_pkg::word_t    head_result,
  output rob_pkg::addr_t    head_target,
  input  logic              head_retire,
  input  logic              flush_valid
);

  rob_pkg::rob_idx_t      head;
  rob_pkg::rob_idx_t      tail;
  logic [`ROB_IDX_W:0]    count;
  logic [`ROB_DEPTH-1:0]  e_done;
  logic [`ROB_DEPTH-1:0]  e_issued;
  rob_pkg::addr_t         e_pc     [`ROB_DEPTH];
  rob_pkg::opcode_t       e_opcode [`ROB_DEPTH];
  rob_pkg::reg_idx_t      e_rd     [`ROB_DEPTH];
  rob_pkg::funct3_t       e_funct3 [`ROB_DEPTH];
  rob_pkg::word_t         e_imm    [`ROB_DEPTH];
  rob_pkg::word_t         e_result [`ROB_DEPTH];
  rob_pkg::addr_t         e_target [`ROB_DEPTH];
  rob_pkg::rob_idx_t      issue_sel;
  logic                   push_fire;
  logic                   wb_hit;

  assign push_ready = int'(count) < `ROB_DEPTH;
  assign push_fire  = push_valid && push_ready;
  // stale writebacks from before a flush find their slot unissued
  assign wb_hit     = wb_valid && e_issued[wb_idx];

  // oldest entry not yet sent to the execution port
  always_comb begin : issue_scan
    rob_pkg::rob_idx_t scan_idx;
    issue_valid = 1'b0;
    issue_sel   = head;
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      scan_idx = head + rob_pkg::rob_idx_t'(i);
      if (!issue_valid && i < int'(count) && !e_issued[scan_idx]) begin
        issue_valid = 1'b1;
        issue_sel   = scan_idx;
      end
    end
  end

  assign issue_idx    = issue_sel;
  assign issue_pc     = e_pc[issue_sel];
  assign issue_opcode = e_opcode[issue_sel];
  assign issue_imm    = e_imm[issue_sel];

  assign head_valid  = (count != '0) && e_done[head];
  assign head_pc     = e_pc[head];
  assign head_opcode = e_opcode[head];
  assign head_rd     = e_rd[head];
  assign head_funct3 = e_funct3[head];
  assign head_result = e_result[head];
  assign head_target = e_target[head];

  always_ff @(posedge clk) begin
    if (rst || flush_valid) begin
      head     <= '0;
      tail     <= '0;
      count    <= '0;
      e_done   <= '0;
      e_issued <= '0;
    end else begin
      if (push_fire) begin
        tail             <= tail + 1'b1;
        e_done[tail]     <= 1'b0;
        e_issued[tail]   <= 1'b0;
      end
      if (issue_valid && issue_ready) begin
        e_issued[issue_sel] <= 1'b1;
      end
      if (wb_hit) begin
        e_done[wb_idx] <= 1'b1;
      end
      if (head_retire) begin
        head <= head + 1'b1;
      end
      case ({push_fire, head_retire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // entry payload
  always_ff @(posedge clk) begin
    if (push_fire) begin
      e_pc[tail]     <= push_pc;
      e_opcode[tail] <= push_opcode;
      e_rd[tail]     <= push_rd;
      e_funct3[tail] <= push_funct3;
      e_imm[tail]    <= push_imm;
    end
    if (wb_hit) begin
      e_result[wb_idx] <= wb_result;
      e_target[wb_idx] <= wb_target;
    end
  end

endmodule

// ==== hw/commit_unit.sv ====
`timescale 1ns/1ps
`include "rob_settings.svh"

module commit_unit (
  input  logic                clk,
  input  logic                rst,
  input  logic                head_valid,
  input  rob_pkg::addr_t      head_pc,
  input  rob_pkg::opcode_t    head_opcode,
  input  rob_pkg::reg_idx_t   head_rd,
  input  rob_pkg::funct3_t    head_funct3,
  input  rob_pkg::word_t      head_result,
  input  rob_pkg::addr_t      head_target,
  output logic                head_retire,
  output logic                reg_commit_valid,
  output rob_pkg::reg_idx_t   reg_commit_rd,
  output rob_pkg::word_t      reg_commit_value,
  output logic                store_valid,
  output rob_pkg::addr_t      store_addr,
  output rob_pkg::word_t      store_data,
  output rob_pkg::store_len_t store_len,
  input  logic                store_ready,
  output logic                flush_valid,
  output rob_pkg::addr_t      flush_pc
);

  rob_pkg::commit_state_e state;
  logic                   is_store;
  logic                   is_branch;
  logic                   is_jalr;

  assign is_store  = head_opcode == `OPC_STORE;
  assign is_branch = head_opcode == `OPC_BRANCH;
  assign is_jalr   = head_opcode == `OPC_JALR;

  // hold off while a store waits or a flush is on its way out
  assign head_retire = (state == rob_pkg::COMMIT_IDLE) && head_valid && !flush_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      state            <= rob_pkg::COMMIT_IDLE;
      reg_commit_valid <= 1'b0;
      store_valid      <= 1'b0;
      flush_valid      <= 1'b0;
    end else begin
      reg_commit_valid <= 1'b0;
      flush_valid      <= 1'b0;
      if (state == rob_pkg::COMMIT_STORING) begin
        if (store_ready) begin
          store_valid <= 1'b0;
          state       <= rob_pkg::COMMIT_IDLE;
        end
      end else if (head_retire) begin
        if (is_store) begin
          store_valid <= 1'b1;
          state       <= rob_pkg::COMMIT_STORING;
        end else if (is_branch) begin
          // predicted taken, so only a not-taken outcome redirects
          flush_valid <= !head_result[0];
        end else begin
          // jal and alu ops alike, jalr also redirects
          reg_commit_valid <= head_rd != '0;
          flush_valid      <= is_jalr;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (head_retire) begin
      reg_commit_rd    <= head_rd;
      reg_commit_value <= head_result;
      store_addr       <= head_target;
      store_data       <= head_result;
      // funct3 word code 2 maps to len 3
      store_len        <= (head_funct3[1:0] == 2'd2) ? 2'd3 : head_funct3[1:0];
      flush_pc         <= is_branch ? head_pc + `INSTR_STEP : head_target;
    end
  end

endmodule

// ==== hw/rob_top.sv ====
`timescale 1ns/1ps

module rob_top (
  input  logic                clk,
  input  logic                rst,
  output logic                fetch_req_valid,
  output rob_pkg::addr_t      fetch_req_pc,
  input  logic                fetch_req_ready,
  input  logic                fetch_rsp_valid,
  input  rob_pkg::opcode_t    rsp_opcode,
  input  rob_pkg::reg_idx_t   rsp_rd,
  input  rob_pkg::funct3_t    rsp_funct3,
  input  rob_pkg::word_t      rsp_imm,
  output logic                issue_valid,
  input  logic                issue_ready,
  output rob_pkg::rob_idx_t   issue_idx,
  output rob_pkg::addr_t      issue_pc,
  output rob_pkg::opcode_t    issue_opcode,
  output rob_pkg::word_t      issue_imm,
  input  logic                wb_valid,
  input  rob_pkg::rob_idx_t   wb_idx,
  input  rob_pkg::word_t      wb_result,
  input  rob_pkg::addr_t      wb_target,
  output logic                reg_commit_valid,
  output rob_pkg::reg_idx_t   reg_commit_rd,
  output rob_pkg::word_t      reg_commit_value,
  output logic                store_valid,
  output rob_pkg::addr_t      store_addr,
  output rob_pkg::word_t      store_data,
  output rob_pkg::store_len_t store_len,
  input  logic                store_ready
);

  // fetch to queue
  logic              push_valid;
  logic              push_ready;
  rob_pkg::addr_t    push_pc;
  rob_pkg::opcode_t  push_opcode;
  rob_pkg::reg_idx_t push_rd;
  rob_pkg::funct3_t  push_funct3;
  rob_pkg::word_t    push_imm;

  // queue head to commit
  logic              head_valid;
  rob_pkg::addr_t    head_pc;
  rob_pkg::opcode_t  head_opcode;
  rob_pkg::reg_idx_t head_rd;
  rob_pkg::funct3_t  head_funct3;
  rob_pkg::word_t    head_result;
  rob_pkg::addr_t    head_target;
  logic              head_retire;

  // redirect back to fetch and queue
  logic              flush_valid;
  rob_pkg::addr_t    flush_pc;

  fetch_sequencer u_fetch (
    .clk             (clk),
    .rst             (rst),
    .fetch_req_valid (fetch_req_valid),
    .fetch_req_pc    (fetch_req_pc),
    .fetch_req_ready (fetch_req_ready),
    .fetch_rsp_valid (fetch_rsp_valid),
    .rsp_opcode      (rsp_opcode),
    .rsp_rd          (rsp_rd),
    .rsp_funct3      (rsp_funct3),
    .rsp_imm         (rsp_imm),
    .push_valid      (push_valid),
    .push_ready      (push_ready),
    .push_pc         (push_pc),
    .push_opcode     (push_opcode),
    .push_rd         (push_rd),
    .push_funct3     (push_funct3),
    .push_imm        (push_imm),
    .flush_valid     (flush_valid),
    .flush_pc        (flush_pc)
  );

  reorder_queue u_queue (
    .clk          (clk),
    .rst          (rst),
    .push_valid   (push_valid),
    .push_ready   (push_ready),
    .push_pc      (push_pc),
    .push_opcode  (push_opcode),
    .push_rd      (push_rd),
    .push_funct3  (push_funct3),
    .push_imm     (push_imm),
    .issue_valid  (issue_valid),
    .issue_ready  (issue_ready),
    .issue_idx    (issue_idx),
    .issue_pc     (issue_pc),
    .issue_opcode (issue_opcode),
    .issue_imm    (issue_imm),
    .wb_valid     (wb_valid),
    .wb_idx       (wb_idx),
    .wb_result    (wb_result),
    .wb_target    (wb_target),
    .head_valid   (head_valid),
    .head_pc      (head_pc),
    .head_opcode  (head_opcode),
    .head_rd      (head_rd),
    .head_funct3  (head_funct3),
    .head_result  (head_result),
    .head_target  (head_target),
    .head_retire  (head_retire),
    .flush_valid  (flush_valid)
  );

  commit_unit u_commit (
    .clk              (clk),
    .rst              (rst),
    .head_valid       (head_valid),
    .head_pc          (head_pc),
    .head_opcode      (head_opcode),
    .head_rd          (head_rd),
    .head_funct3      (head_funct3),
    .head_result      (head_result),
    .head_target      (head_target),
    .head_retire      (head_retire),
    .reg_commit_valid (reg_commit_valid),
    .reg_commit_rd    (reg_commit_rd),
    .reg_commit_value (reg_commit_value),
    .store_valid      (store_valid),
    .store_addr       (store_addr),
    .store_data       (store_data),
    .store_len        (store_len),
    .store_ready      (store_ready),
    .flush_valid      (flush_valid),
    .flush_pc         (flush_pc)
  );

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

endmodule

// ==== sim/rob_properties.sv ====
`timescale 1ns/1ps

module rob_properties (
  input logic                clk,
  input logic                rst,
  input logic                flush_valid,
  input logic                fetch_req_valid,
  input logic                fetch_req_ready,
  input rob_pkg::addr_t      fetch_req_pc,
  input logic                issue_valid,
  input logic                issue_ready,
  input rob_pkg::rob_idx_t   issue_idx,
  input rob_pkg::addr_t      issue_pc,
  input rob_pkg::opcode_t    issue_opcode,
  input rob_pkg::word_t      issue_imm,
  input logic                store_valid,
  input logic                store_ready,
  input rob_pkg::addr_t      store_addr,
  input rob_pkg::word_t      store_data,
  input rob_pkg::store_len_t store_len,
  input logic                reg_commit_valid
);

  // failure counts per property
  int store_hold_fails = 0;
  int issue_hold_fails = 0;
  int fetch_hold_fails = 0;
  int commit_block_fails = 0;

  store_hold: assert property (@(posedge clk) disable iff (rst)
    store_valid && !store_ready |=> store_valid && $stable(store_addr) &&
    $stable(store_data) && $stable(store_len))
    else begin
      store_hold_fails++;
      $error("store request changed before it was accepted");
    end

  // a flush legally withdraws the offered entry
  issue_hold: assert property (@(posedge clk) disable iff (rst)
    issue_valid && !issue_ready && !flush_valid |=> issue_valid &&
    $stable(issue_idx) && $stable(issue_pc) && $stable(issue_opcode) &&
    $stable(issue_imm))
    else begin
      issue_hold_fails++;
      $error("issue offer changed before it was accepted");
    end

  fetch_hold: assert property (@(posedge clk) disable iff (rst)
    fetch_req_valid && !fetch_req_ready && !flush_valid |=> fetch_req_valid &&
    $stable(fetch_req_pc))
    else begin
      fetch_hold_fails++;
      $error("fetch request dropped before it was accepted");
    end

  store_blocks_commit: assert property (@(posedge clk) disable iff (rst)
    store_valid |-> !reg_commit_valid)
    else begin
      commit_block_fails++;
      $error("register commit while a store waits");
    end

endmodule

bind rob_top rob_properties u_rob_properties (
  .clk              (clk),
  .rst              (rst),
  .flush_valid      (flush_valid),
  .fetch_req_valid  (fetch_req_valid),
  .fetch_req_ready  (fetch_req_ready),
  .fetch_req_pc     (fetch_req_pc),
  .issue_valid      (issue_valid),
  .issue_ready      (issue_ready),
  .issue_idx        (issue_idx),
  .issue_pc         (issue_pc),
  .issue_opcode     (issue_opcode),
  .issue_imm        (issue_imm),
  .store_valid      (store_valid),
  .store_ready      (store_ready),
  .store_addr       (store_addr),
  .store_data       (store_data),
  .store_len        (store_len),
  .reg_commit_valid (reg_commit_valid)
);

// ==== sim/rob_tb.sv ====
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_tb;

  localparam rob_pkg::opcode_t OPC_ALU = 7'b0110011;
  localparam rob_pkg::addr_t END_PC = 32'h0000_00a8;
  localparam rob_pkg::word_t RES_MASK = 32'h5a5a_5a5a;
  localparam int CYCLE_LIMIT = 5000;

  logic clk;
  logic rst;
  logic fetch_req_valid;
  logic fetch_req_ready;
  logic fetch_rsp_valid;
  rob_pkg::addr_t fetch_req_pc;
  rob_pkg::opcode_t rsp_opcode;
  rob_pkg::reg_idx_t rsp_rd;
  rob_pkg::funct3_t rsp_funct3;
  rob_pkg::word_t rsp_imm;
  logic issue_valid;
  logic issue_ready;
  rob_pkg::rob_idx_t issue_idx;
  rob_pkg::addr_t issue_pc;
  rob_pkg::opcode_t issue_opcode;
  rob_pkg::word_t issue_imm;
  logic wb_valid;
  rob_pkg::rob_idx_t wb_idx;
  rob_pkg::word_t wb_result;
  rob_pkg::addr_t wb_target;
  logic reg_commit_valid;
  rob_pkg::reg_idx_t reg_commit_rd;
  rob_pkg::word_t reg_commit_value;
  logic store_valid;
  logic store_ready;
  rob_pkg::addr_t store_addr;
  rob_pkg::word_t store_data;
  rob_pkg::store_len_t store_len;

  // program table indexed by pc/4
  rob_pkg::opcode_t t_opc [64];
  logic [4:0] t_rd [64];
  logic [2:0] t_f3 [64];
  rob_pkg::word_t t_imm [64];
  logic t_taken [64];
  rob_pkg::addr_t t_target [64];

  // expected commits with kind 0 for a register and 1 for a store
  int exp_kind[$];
  logic [31:0] exp_a[$];
  logic [31:0] exp_b[$];
  logic [31:0] exp_c[$];

  // execution model in flight
  rob_pkg::rob_idx_t px_idx[$];
  rob_pkg::word_t px_result[$];
  rob_pkg::addr_t px_target[$];
  int px_wait[$];

  logic [31:0] rng_state;
  int errors;
  int checks;
  int tests_done;
  int cycles;
  int drain;
  logic [6:1] test_flag;
  logic rsp_pending;
  logic have_last;
  logic jalr_seen;
  int rsp_wait;
  int stall_left;
  int stall_fetches;
  rob_pkg::addr_t rsp_pc;
  rob_pkg::addr_t last_fetch;

  tb_clock u_clock (.clk(clk));

  rob_top u_rob_top (.*);

  function automatic int tidx(rob_pkg::addr_t pc);
    return int'(pc[7:2]);
  endfunction

  function int unsigned rand_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return {16'h0, rng_state[31:16]};
  endfunction

  function automatic rob_pkg::addr_t predict_next(rob_pkg::addr_t pc);
    int i;
    i = tidx(pc);
    if (t_opc[i] == `OPC_BRANCH || t_opc[i] == `OPC_JAL) begin
      return pc + t_imm[i];
    end
    return pc + 32'd4;
  endfunction

  // byte 0, halfword 1, word 3
  function automatic logic [1:0] store_len_code(input logic [2:0] f3);
    case (f3[1:0])
      2'd0:    return 2'd0;
      2'd1:    return 2'd1;
      default: return 2'd3;
    endcase
  endfunction

  task automatic set_entry(input int i, input rob_pkg::opcode_t opc, input logic [4:0] rd,
                           input logic [2:0] f3, input rob_pkg::word_t imm,
                           input logic taken, input rob_pkg::addr_t target);
    t_opc[i] = opc;
    t_rd[i] = rd;
    t_f3[i] = f3;
    t_imm[i] = imm;
    t_taken[i] = taken;
    t_target[i] = target;
  endtask

  task automatic load_program();
    for (int i = 0; i < 64; i++) begin
      set_entry(i, OPC_ALU, 5'd0, 3'd0, 32'(i * 4) ^ 32'h1357_9bdf, 1'b0, 32'(i * 4) + 32'h200);
    end
    set_entry(0, OPC_ALU, 5'd1, 3'd0, 32'd0, 1'b0, 32'd0);
    set_entry(2, OPC_ALU, 5'd2, 3'd0, 32'd0, 1'b0, 32'd0);
    set_entry(3, `OPC_JAL, 5'd3, 3'd0, 32'd8, 1'b0, 32'd0);
    set_entry(4, OPC_ALU, 5'd9, 3'd0, 32'd0, 1'b0, 32'd0);
    set_entry(5, `OPC_STORE, 5'd0, 3'd2, 32'd0, 1'b0, 32'h100);
    set_entry(6, `OPC_STORE, 5'd0, 3'd1, 32'd0, 1'b0, 32'h104);
    set_entry(7, `OPC_BRANCH, 5'd0, 3'd0, 32'd8, 1'b1, 32'd0);
    set_entry(8, OPC_ALU, 5'd9, 3'd0, 32'd0, 1'b0, 32'd0);
    set_entry(9, `OPC_BRANCH, 5'd0, 3'd1, 32'd16, 1'b0, 32'd0);
    set_entry(10, OPC_ALU, 5'd4, 3'd0, 32'd0, 1'b0, 32'd0);
    set_entry(11, `OPC_JALR, 5'd5, 3'd0, 32'd0, 1'b0, 32'h80);
    for (int i = 12; i < 15; i++) begin
      set_entry(i, OPC_ALU, 5'd9, 3'd0, 32'd0, 1'b0, 32'd0);
    end
    for (int i = 32; i < 42; i++) begin
      set_entry(i, OPC_ALU, 5'(i - 26), 3'd0, 32'd0, 1'b0, 32'd0);
    end
    // self loop closes the program
    set_entry(42, `OPC_JAL, 5'd0, 3'd0, 32'd0, 1'b0, 32'd0);
  endtask

  // walk the program along its committed path
  task automatic build_expected();
    rob_pkg::addr_t pc;
    int i;
    int steps;
    pc = '0;
    steps = 0;
    while (pc != END_PC && steps < 200) begin
      i = tidx(pc);
      steps++;
      if (t_opc[i] == `OPC_STORE) begin
        exp_kind.push_back(1);
        exp_a.push_back(t_target[i]);
        exp_b.push_back(pc ^ RES_MASK);
        exp_c.push_back(32'(store_len_code(t_f3[i])));
        pc = pc + 32'd4;
      end else if (t_opc[i] == `OPC_BRANCH) begin
        pc = t_taken[i] ? pc + t_imm[i] : pc + 32'd4;
      end else begin
        if (t_rd[i] != 5'd0) begin
          exp_kind.push_back(0);
          exp_a.push_back(32'(t_rd[i]));
          exp_b.push_back(pc ^ RES_MASK);
          exp_c.push_back(32'd0);
        end
        if (t_opc[i] == `OPC_JAL) begin
          pc = pc + t_imm[i];
        end else if (t_opc[i] == `OPC_JALR) begin
          pc = t_target[i];
        end else begin
          pc = pc + 32'd4;
        end
      end
    end
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Error: %s", what);
    end
  endtask

  task automatic finish_test(input int n, input string name);
    if (!test_flag[n]) begin
      test_flag[n] = 1'b1;
      tests_done++;
      $display("test %0d %s finished, errors so far %0d", n, name, errors);
    end
  endtask

  // sampled at negedge so each handshake seen here fires at the next rising edge
  task automatic sample_cycle();
    int i;
    rob_pkg::word_t res;
    rob_pkg::addr_t tgt;
    if (fetch_req_valid && fetch_req_ready) begin
      if (stall_left > 0) begin
        stall_fetches++;
      end
      if (jalr_seen) begin
        check_eq("fetch_req_pc", fetch_req_pc, 32'h80);
        jalr_seen = 1'b0;
        finish_test(5, "jalr redirect");
      end else if (have_last && last_fetch <= 32'd12) begin
        check_eq("fetch_req_pc", fetch_req_pc, predict_next(last_fetch));
        if (last_fetch == 32'd12) begin
          finish_test(2, "jal prediction");
        end
      end
      last_fetch = fetch_req_pc;
      have_last = 1'b1;
      rsp_pending = 1'b1;
      rsp_pc = fetch_req_pc;
      rsp_wait = int'(rand_next() % 3);
    end
    if (reg_commit_valid) begin
      check_true(exp_kind.size() > 0 && exp_kind[0] == 0, "register commit not expected here");
      if (exp_kind.size() > 0 && exp_kind[0] == 0) begin
        void'(exp_kind.pop_front());
        void'(exp_c.pop_front());
        check_eq("reg_commit_rd", 32'(reg_commit_rd), exp_a.pop_front());
        check_eq("reg_commit_value", reg_commit_value, exp_b.pop_front());
      end
      if (reg_commit_rd == 5'd2) begin
        finish_test(1, "straight-line alu");
      end
      if (reg_commit_rd == 5'd4) begin
        finish_test(4, "branch outcomes");
      end
      if (reg_commit_rd == 5'd5) begin
        jalr_seen = 1'b1;
        stall_left = 80;
        stall_fetches = 0;
      end
    end
    if (store_valid && store_ready) begin
      check_true(exp_kind.size() > 0 && exp_kind[0] == 1, "store not expected here");
      if (exp_kind.size() > 0 && exp_kind[0] == 1) begin
        void'(exp_kind.pop_front());
        check_eq("store_addr", store_addr, exp_a.pop_front());
        check_eq("store_data", store_data, exp_b.pop_front());
        check_eq("store_len", 32'(store_len), exp_c.pop_front());
      end
      if (store_addr == 32'h104) begin
        finish_test(3, "store handshake");
      end
    end
    if (stall_left == 1) begin
      check_true(stall_fetches == `ROB_DEPTH, "queue did not fill to its depth during the stall");
      check_true(!fetch_req_valid, "fetch still requesting with a full queue");
      finish_test(6, "full queue");
    end
    if (u_rob_top.flush_valid) begin
      // flushed work never writes back
      px_idx.delete();
      px_result.delete();
      px_target.delete();
      px_wait.delete();
    end else if (issue_valid && issue_ready) begin
      i = tidx(issue_pc);
      check_eq("issue_opcode", 32'(issue_opcode), 32'(t_opc[i]));
      check_eq("issue_imm", issue_imm, t_imm[i]);
      if (issue_opcode == `OPC_BRANCH) begin
        res = 32'(t_taken[i]);
        tgt = '0;
      end else begin
        res = issue_pc ^ RES_MASK;
        tgt = t_target[i];
      end
      px_idx.push_back(issue_idx);
      px_result.push_back(res);
      px_target.push_back(tgt);
      px_wait.push_back(int'(rand_next() % 4));
    end
  endtask

  task automatic drive_cycle();
    int pick;
    fetch_req_ready = (rand_next() % 4) != 0;
    store_ready = (rand_next() % 3) == 0;
    issue_ready = (stall_left == 0) && ((rand_next() % 2) == 1);
    if (stall_left > 0) begin
      stall_left--;
    end
    fetch_rsp_valid = 1'b0;
    if (rsp_pending) begin
      if (rsp_wait == 0) begin
        fetch_rsp_valid = 1'b1;
        rsp_opcode = t_opc[tidx(rsp_pc)];
        rsp_rd = t_rd[tidx(rsp_pc)];
        rsp_funct3 = t_f3[tidx(rsp_pc)];
        rsp_imm = t_imm[tidx(rsp_pc)];
        rsp_pending = 1'b0;
      end else begin
        rsp_wait--;
      end
    end
    wb_valid = 1'b0;
    pick = -1;
    for (int k = 0; k < px_wait.size(); k++) begin
      if (px_wait[k] > 0) begin
        px_wait[k]--;
      end else if (pick < 0) begin
        pick = k;
      end
    end
    if (pick >= 0) begin
      wb_valid = 1'b1;
      wb_idx = px_idx[pick];
      wb_result = px_result[pick];
      wb_target = px_target[pick];
      px_idx.delete(pick);
      px_result.delete(pick);
      px_target.delete(pick);
      px_wait.delete(pick);
    end
  endtask

  initial begin
    rst = 1'b1;
    fetch_req_ready = 1'b0;
    fetch_rsp_valid = 1'b0;
    rsp_opcode = '0;
    rsp_rd = '0;
    rsp_funct3 = '0;
    rsp_imm = '0;
    issue_ready = 1'b0;
    wb_valid = 1'b0;
    wb_idx = '0;
    wb_result = '0;
    wb_target = '0;
    store_ready = 1'b0;
    rng_state = 32'd47408;
    errors = 0;
    checks = 0;
    tests_done = 0;
    test_flag = '0;
    rsp_pending = 1'b0;
    have_last = 1'b0;
    jalr_seen = 1'b0;
    rsp_wait = 0;
    stall_left = 0;
    stall_fetches = 0;
    drain = 0;
    load_program();
    build_expected();
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
    cycles = 0;
    while (drain != 1 && cycles < CYCLE_LIMIT) begin
      @(negedge clk);
      sample_cycle();
      if (drain > 1) begin
        drain--;
      end else if (drain == 0 && exp_kind.size() == 0 && tests_done == 6) begin
        drain = 30;
      end
      @(posedge clk);
      #1;
      drive_cycle();
      cycles++;
    end
    if (cycles >= CYCLE_LIMIT) begin
      errors++;
      $display("Error: timeout with %0d commits still expected", exp_kind.size());
    end
    errors += u_rob_top.u_rob_properties.store_hold_fails +
              u_rob_top.u_rob_properties.issue_hold_fails +
              u_rob_top.u_rob_properties.fetch_hold_fails +
              u_rob_top.u_rob_properties.commit_block_fails;
    $display("tests finished %0d of 6, checks %0d, errors %0d", tests_done, checks, errors);
    if (errors == 0 && tests_done == 6) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+hw
hw/rob_pkg.sv
hw/fetch_sequencer.sv
hw/reorder_queue.sv
hw/commit_unit.sv
hw/rob_top.sv
sim/tb_clock.sv
sim/rob_properties.sv
sim/rob_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the reorder queue testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module rob_tb -o rob_sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/rob_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF '*** PASSED ***' sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
